// File: common/vfu_pkg.sv
/*
  Instruction-side types of the vector integer unit.
  Element counts (vl) are limited to 16 bits. A tag counts at most
  127 valid elements per word, which bounds the lane count at 16.
*/
`default_nettype none

package vfu_pkg;

  localparam int unsigned ID_WIDTH      = 2;
  localparam int unsigned GPR_WIDTH     = 5;
  localparam int unsigned VL_WIDTH      = 16;
  localparam int unsigned NR_ELEM_WIDTH = 7;

  typedef logic [ID_WIDTH-1:0]      id_t;
  typedef logic [GPR_WIDTH-1:0]     gpr_t;
  typedef logic [4:0]               vreg_t;
  typedef logic [VL_WIDTH-1:0]      vlen_t;
  typedef logic [NR_ELEM_WIDTH-1:0] nr_elem_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } ew_e;

  // Integer operations, min and max are unsigned
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMINU,
    VMAXU
  } vfu_op_e;

  typedef struct packed {
    id_t         id;
    vfu_op_e     op;
    ew_e         vsew;
    vlen_t       vl;
    vreg_t       vs1;
    vreg_t       vs2;
    vreg_t       vd;
    logic        use_vs1;
    logic        is_scalar;
    logic [31:0] rs1;
    logic [31:0] rs2;
    gpr_t        rd;
  } vfu_req_t;

  typedef struct packed {
    id_t         id;
    gpr_t        rd;
    logic        wb;
    logic [31:0] result;
  } vfu_rsp_t;

  // Follows each word through the lanes
  typedef struct packed {
    id_t      id;
    gpr_t     rd;
    logic     wb;
    logic     last;
    nr_elem_t nr_valid_elem;
  } vfu_tag_t;

endpackage : vfu_pkg

`default_nettype wire

// File: common/vrf_pkg.sv
/*
  Register-file-side sizes and types. Each lane holds one ELEN word.
  The address covers NR_VREGS registers of WORDS_PER_VREG words each.
  The lane word union assumes ELEN is 32.
*/
`default_nettype none

package vrf_pkg;

  // Lane word size
  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  // Register file geometry
  localparam int unsigned WORDS_PER_VREG = 4;
  localparam int unsigned NR_VREGS       = 32;
  localparam int unsigned VADDR_WIDTH    = $clog2(NR_VREGS * WORDS_PER_VREG);

  typedef logic [VADDR_WIDTH-1:0] vreg_addr_t;
  typedef logic [ELEN-1:0]        elen_t;

  // One lane word seen at each element width
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
    logic [ELEN-1:0]  w;
  } lane_word_u;

endpackage : vrf_pkg

`default_nettype wire

// File: dv/spatz_vfu_asserts.sv
/*
  Protocol assertions bound to the vector unit top.
  Clocked on the rising edge and quiet while reset is low.
*/
`timescale 1ns/10ps
`default_nettype none

module spatz_vfu_asserts #(
  parameter int unsigned N_LANES = 2
) (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input vfu_pkg::vfu_rsp_t                   rsp_i,
  input logic                                rsp_valid_i,
  input logic                                we_i,
  input logic [N_LANES*vrf_pkg::ELENB-1:0]   wbe_i,
  input logic                                issue_i,
  input logic                                scalar_i
);
  import vfu_pkg::*;

  int unsigned fail_cnt = 0;

  // A write always touches at least one byte
  a_we_has_bytes : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> (wbe_i != '0))
    else begin
      fail_cnt++;
      $error("write with empty byte enable");
    end

  // Back-to-back responses belong to different instructions
  a_rsp_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i ##1 rsp_valid_i |-> (rsp_i.id != $past(rsp_i.id)))
    else begin
      fail_cnt++;
      $error("two responses in a row for one id");
    end

  // Scalar results never reach the VRF, results land one cycle after issue
  a_no_scalar_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_i && scalar_i |=> !we_i)
    else begin
      fail_cnt++;
      $error("VRF write for a scalar tag");
    end

endmodule : spatz_vfu_asserts

`default_nettype wire

// File: dv/tb_spatz_vfu.sv
/*
  Testbench for the vector integer unit with a VRF model.
  Cases come from dv/vfu_cases.txt. Each case uses its own registers,
  so no case reads a register that another case writes.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_spatz_vfu;
  import vfu_pkg::*;
  import vrf_pkg::*;

  localparam int unsigned N_LANES   = 2;
  localparam int unsigned WORD_W    = N_LANES * ELEN;
  localparam int unsigned MAX_CASES = 16;

  logic                         clk;
  logic                         rst_n;
  vfu_req_t                     req;
  logic                         req_valid;
  logic                         req_ready;
  vfu_rsp_t                     rsp;
  logic                         rsp_valid;
  logic                         rsp_ready;
  vreg_addr_t [1:0]             vrf_raddr;
  logic [1:0]                   vrf_re;
  logic [1:0][WORD_W-1:0]       vrf_rdata;
  logic [1:0]                   vrf_rvalid;
  vreg_addr_t                   vrf_waddr;
  logic [WORD_W-1:0]            vrf_wdata;
  logic                         vrf_we;
  logic [N_LANES*ELENB-1:0]     vrf_wbe;

  logic [WORD_W-1:0] vrf [128];
  integer            seed = 32'hb253_acf8;
  int                cycle_cnt = 0;
  int                cycle_limit = 100000;
  int                rsp_cnt = 0;
  int                n_cases = 0;

  // Case table
  string             names [MAX_CASES];
  vfu_req_t          reqs [MAX_CASES];
  logic [WORD_W-1:0] pat1 [MAX_CASES];
  logic [WORD_W-1:0] pat2 [MAX_CASES];
  logic [WORD_W-1:0] exp_words [MAX_CASES][4];
  int                n_words [MAX_CASES];
  vfu_rsp_t          exp_rsp_q [$];
  string             rsp_name_q [$];

  spatz_vfu #(
    .N_LANES (N_LANES)
  ) i_spatz_vfu (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .rsp_o        (rsp),
    .rsp_valid_o  (rsp_valid),
    .rsp_ready_i  (rsp_ready),
    .vrf_raddr_o  (vrf_raddr),
    .vrf_re_o     (vrf_re),
    .vrf_rdata_i  (vrf_rdata),
    .vrf_rvalid_i (vrf_rvalid),
    .vrf_waddr_o  (vrf_waddr),
    .vrf_wdata_o  (vrf_wdata),
    .vrf_we_o     (vrf_we),
    .vrf_wbe_o    (vrf_wbe)
  );

  bind spatz_vfu spatz_vfu_asserts #(.N_LANES(N_LANES)) i_spatz_vfu_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rsp_i       (rsp_o),
    .rsp_valid_i (rsp_valid_o),
    .we_i        (vrf_we_o),
    .wbe_i       (vrf_wbe_o),
    .issue_i     (issue),
    .scalar_i    (head_req.is_scalar)
  );

  always #5 clk = ~clk;

  // Every byte of a word holds its own address
  function automatic logic [WORD_W-1:0] fill_word(input int unsigned addr);
    return {(WORD_W / 8){8'(addr)}};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] exp_w,
                            input logic [WORD_W-1:0] act_w);
    if (act_w !== exp_w) begin
      stop_on_error($sformatf("mismatch %s: expected %h actual %h", name, exp_w, act_w));
    end
  endtask

  task automatic check_rsp(input string name, input vfu_rsp_t exp_r, input vfu_rsp_t act_r);
    if (act_r !== exp_r) begin
      stop_on_error($sformatf("mismatch %s: expected %h actual %h", name, exp_r, act_r));
    end
  endtask

  task automatic read_cases();
    int          fd;
    string       line;
    string       nm;
    int          op, ew, vl, u1, sc, v1, v2, vd, rd;
    logic [31:0] r1, r2;
    logic [63:0] p1, p2, e0, e1, e2, e3;
    int          epw;
    int          total;
    fd = $fopen("dv/vfu_cases.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open dv/vfu_cases.txt");
    end
    total = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 4 || line.substr(0, 0) == "#") begin
        continue;
      end
      void'($sscanf(line, "%s %d %d %d %d %d %d %d %d %d %h %h %h %h %h %h %h %h",
                    nm, op, ew, vl, u1, sc, v1, v2, vd, rd, r1, r2, p1, p2, e0, e1, e2, e3));
      names[n_cases] = nm;
      reqs[n_cases]  = '{id: id_t'(n_cases), op: vfu_op_e'(op), vsew: ew_e'(ew),
                         vl: vlen_t'(vl), vs1: vreg_t'(v1), vs2: vreg_t'(v2),
                         vd: vreg_t'(vd), use_vs1: u1[0], is_scalar: sc[0],
                         rs1: r1, rs2: r2, rd: gpr_t'(rd)};
      pat1[n_cases] = p1;
      pat2[n_cases] = p2;
      exp_words[n_cases] = '{e0, e1, e2, e3};
      epw = N_LANES * (4 >> ew);
      n_words[n_cases] = sc ? 1 : (vl + epw - 1) / epw;
      total += n_words[n_cases];
      n_cases++;
    end
    $fclose(fd);
    cycle_limit = 20 * total + 100;
  endtask

  // VRF stalls and response back-pressure
  always @(negedge clk) begin
    vrf_rvalid = 2'(($random(seed) & 3) != 0 ? 2'b11 : 2'(($random(seed) & 3)));
    rsp_ready  = ($random(seed) % 4) != 0;
  end

  // Only enabled ports return data
  assign vrf_rdata[0] = vrf_re[0] ? vrf[vrf_raddr[0]] : 'x;
  assign vrf_rdata[1] = vrf_re[1] ? vrf[vrf_raddr[1]] : 'x;

  // Write and response monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (i_spatz_vfu.i_spatz_vfu_asserts.fail_cnt != 0) begin
      stop_on_error("a bound assertion failed");
    end
    if (vrf_we === 1'b1) begin
      for (int b = 0; b < N_LANES * ELENB; b++) begin
        if (vrf_wbe[b]) begin
          vrf[vrf_waddr][b*8 +: 8] = vrf_wdata[b*8 +: 8];
        end
      end
    end
    if (rsp_valid === 1'b1) begin
      if (exp_rsp_q.size() == 0) begin
        stop_on_error("response arrived with no instruction pending");
      end
      check_rsp(rsp_name_q.pop_front(), exp_rsp_q.pop_front(), rsp);
      rsp_cnt++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      stop_on_error($sformatf("timeout: run exceeded %0d cycles", cycle_limit));
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    rsp_ready  = 1'b0;
    vrf_rvalid = 2'b00;
    read_cases();
    for (int a = 0; a < 128; a++) begin
      vrf[a] = fill_word(a);
    end
    for (int c = 0; c < n_cases; c++) begin
      for (int w = 0; w < 4; w++) begin
        if (!reqs[c].is_scalar) begin
          vrf[reqs[c].vs2 * 4 + w] = pat2[c];
        end
        if (!reqs[c].is_scalar && reqs[c].use_vs1) begin
          vrf[reqs[c].vs1 * 4 + w] = pat1[c];
        end
      end
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // All cases go back to back through the queue
    for (int c = 0; c < n_cases; c++) begin
      exp_rsp_q.push_back('{id: reqs[c].id, rd: reqs[c].rd, wb: reqs[c].is_scalar,
                            result: reqs[c].is_scalar ? exp_words[c][0][31:0] : 32'd0});
      rsp_name_q.push_back(names[c]);
      @(negedge clk);
      req       = reqs[c];
      req_valid = 1'b1;
      while (!req_ready) begin
        @(negedge clk);
      end
    end
    @(negedge clk);
    req_valid = 1'b0;

    while (rsp_cnt < n_cases) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);

    for (int c = 0; c < n_cases; c++) begin
      if (reqs[c].is_scalar) begin
        // Scalar vd stays at its fill
        check_word(names[c], fill_word(reqs[c].vd * 4), vrf[reqs[c].vd * 4]);
      end else begin
        for (int w = 0; w < n_words[c]; w++) begin
          check_word($sformatf("%s word %0d", names[c], w), exp_words[c][w],
                     vrf[reqs[c].vd * 4 + w]);
        end
      end
    end

    if (i_spatz_vfu.i_spatz_vfu_asserts.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_spatz_vfu

`default_nettype wire

// File: dv/vfu_cases.txt
# name op vsew vl use_vs1 is_scalar vs1 vs2 vd rd rs1 rs2 vs1_pat vs2_pat exp0 exp1 exp2 exp3
# op 0..6 = add sub and or xor minu maxu, vsew 0/1/2 = 8/16/32 bit, exp = vd words or scalar result
add8 0 0 16 1 0 1 2 3 1 00000000 00000000 0102030405060708 10FF20FE30804080 1101230235864788 1101230235864788 0 0
sub16 1 1 6 1 0 4 5 6 2 00000000 00000000 0001000100010005 00051000FFFF0003 00040FFFFFFEFFFE 19191919FFFEFFFE 0 0
and32 2 2 5 1 0 7 8 9 3 00000000 00000000 F0F0F0F00F0F0F0F 123456789ABCDEF0 103050700A0C0E00 103050700A0C0E00 262626260A0C0E00 0
or8_rs1 3 0 11 0 0 0 10 11 4 00000040 00000000 0 0102030481828384 41424344C1C2C3C4 2D2D2D2D2DC2C3C4 0 0
xor16 4 1 16 1 0 12 13 14 5 00000000 00000000 FFFF000012345555 00FF00FF1234AAAA FF0000FF0000FFFF FF0000FF0000FFFF FF0000FF0000FFFF FF0000FF0000FFFF
minu8 5 0 8 1 0 15 16 17 6 00000000 00000000 80017F00FF10200F 0180807FFE11101F 01017F00FE10100F 0 0 0
maxu32_rs1 6 2 4 0 0 0 18 19 8 80000000 00000000 0 7FFFFFFF90000000 8000000090000000 8000000090000000 0 0
sc_add 0 2 1 0 1 0 0 20 7 00000005 FFFFFFFE 0 0 00000003 0 0 0
sc_sub 1 2 1 0 1 0 0 20 9 00000010 00000003 0 0 FFFFFFF3 0 0 0
add32 0 2 8 1 0 21 22 23 10 00000000 00000000 00000001FFFFFFFF FFFFFFFF00000001 0000000000000000 0000000000000000 0000000000000000 0000000000000000

// File: ipu/vfu_ipu.sv
/*
  One 32-bit SIMD integer lane with a single result register.
  Subtraction is vs2 minus vs1 (b_i minus a_i). Min and max are
  unsigned. No carry passes between elements.
*/
`timescale 1ns/10ps
`default_nettype none

module vfu_ipu (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vfu_pkg::vfu_op_e    op_i,
  input  vfu_pkg::ew_e        vsew_i,
  input  vrf_pkg::lane_word_u a_i,
  input  vrf_pkg::lane_word_u b_i,
  input  logic                valid_i,
  output vrf_pkg::lane_word_u result_o,
  output logic                valid_o
);
  import vfu_pkg::*;
  import vrf_pkg::*;

  lane_word_u res;
  logic       valid_q;

  // Zero-extended operands keep min and max unsigned at every width
  function automatic elen_t alu(vfu_op_e op, elen_t a, elen_t b);
    case (op)
      VADD:    return b + a;
      VSUB:    return b - a;
      VAND:    return b & a;
      VOR:     return b | a;
      VXOR:    return b ^ a;
      VMINU:   return (a < b) ? a : b;
      VMAXU:   return (a > b) ? a : b;
      default: return '0;
    endcase
  endfunction

  always_comb begin
    res = '0;
    case (vsew_i)
      EW_8: begin
        for (int i = 0; i < 4; i++) begin
          res.b[i] = 8'(alu(op_i, elen_t'(a_i.b[i]), elen_t'(b_i.b[i])));
        end
      end
      EW_16: begin
        for (int i = 0; i < 2; i++) begin
          res.h[i] = 16'(alu(op_i, elen_t'(a_i.h[i]), elen_t'(b_i.h[i])));
        end
      end
      default: res.w = alu(op_i, a_i.w, b_i.w);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= res;
    end
  end

  assign valid_o = valid_q;

endmodule : vfu_ipu

`default_nettype wire

// File: ipu/vfu_ipu_array.sv
/*
  N_LANES integer lanes plus the tag register. Scalar instructions run
  in lane 0 at 32 bits and the other lanes keep their last result.
  Results and tag appear one cycle after issue.
*/
`timescale 1ns/10ps
`default_nettype none

module vfu_ipu_array #(
  parameter int unsigned N_LANES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vfu_pkg::vfu_req_t                     req_i,
  input  logic                                  issue_i,
  input  vfu_pkg::vfu_tag_t                     tag_i,
  input  logic [1:0][N_LANES*vrf_pkg::ELEN-1:0] vrf_rdata_i,
  output logic [N_LANES*vrf_pkg::ELEN-1:0]      res_o,
  output logic                                  res_valid_o,
  output vfu_pkg::vfu_tag_t                     tag_o
);
  import vfu_pkg::*;
  import vrf_pkg::*;

  localparam int unsigned WORD_W = N_LANES * ELEN;

  logic [WORD_W-1:0]  opa;
  logic [WORD_W-1:0]  opb;
  ew_e                lane_vsew;
  logic [N_LANES-1:0] lane_valid;

  assign lane_vsew = req_i.is_scalar ? EW_32 : req_i.vsew;

  always_comb begin
    opb = req_i.is_scalar ? WORD_W'(req_i.rs2) : vrf_rdata_i[1'b0];
    if (req_i.is_scalar) begin
      opa = WORD_W'(req_i.rs1);
    end else if (req_i.use_vs1) begin
      opa = vrf_rdata_i[1'b1];
    end else begin
      // Replicate rs1 into every element
      case (req_i.vsew)
        EW_8:    opa = {(4 * N_LANES){req_i.rs1[7:0]}};
        EW_16:   opa = {(2 * N_LANES){req_i.rs1[15:0]}};
        default: opa = {N_LANES{req_i.rs1}};
      endcase
    end
  end

  for (genvar l = 0; l < N_LANES; l++) begin : gen_lanes
    vfu_ipu i_ipu (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .op_i     (req_i.op),
      .vsew_i   (lane_vsew),
      .a_i      (opa[l*ELEN +: ELEN]),
      .b_i      (opb[l*ELEN +: ELEN]),
      .valid_i  (issue_i && (!req_i.is_scalar || l == 0)),
      .result_o (res_o[l*ELEN +: ELEN]),
      .valid_o  (lane_valid[l])
    );
  end : gen_lanes

  // Lane 0 fires on every issue
  assign res_valid_o = |lane_valid;

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      tag_o <= tag_i;
    end
  end

endmodule : vfu_ipu_array

`default_nettype wire

// File: sources.f
common/vfu_pkg.sv
common/vrf_pkg.sv
src/vfu_op_queue.sv
src/vfu_ctrl.sv
src/vfu_vrf_requester.sv
ipu/vfu_ipu.sv
ipu/vfu_ipu_array.sv
src/spatz_vfu.sv
dv/spatz_vfu_asserts.sv
dv/tb_spatz_vfu.sv

// File: src/spatz_vfu.sv
/*
  Integer vector functional unit top. VRF read data must be valid in
  the cycle rvalid is high. Writes are never back-pressured. Only one
  response per instruction and responses keep request order.
*/
`timescale 1ns/10ps
`default_nettype none

module spatz_vfu #(
  parameter int unsigned N_LANES = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vfu_pkg::vfu_req_t                     req_i,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  output vfu_pkg::vfu_rsp_t                     rsp_o,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output vrf_pkg::vreg_addr_t [1:0]             vrf_raddr_o,
  output logic [1:0]                            vrf_re_o,
  input  logic [1:0][N_LANES*vrf_pkg::ELEN-1:0] vrf_rdata_i,
  input  logic [1:0]                            vrf_rvalid_i,
  output vrf_pkg::vreg_addr_t                   vrf_waddr_o,
  output logic [N_LANES*vrf_pkg::ELEN-1:0]      vrf_wdata_o,
  output logic                                  vrf_we_o,
  output logic [N_LANES*vrf_pkg::ELENB-1:0]     vrf_wbe_o
);
  import vfu_pkg::*;
  import vrf_pkg::*;

  vfu_req_t                 head_req;
  logic                     head_valid;
  logic                     pop;
  logic                     issue;
  vfu_tag_t                 issue_tag;
  logic                     res_valid;
  vfu_tag_t                 res_tag;
  logic [N_LANES*ELEN-1:0]  res_data;

  ////////////////////////////////////////////////////////////////////////////
  // Queue and control
  ////////////////////////////////////////////////////////////////////////////

  vfu_op_queue i_op_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .req_o   (head_req),
    .valid_o (head_valid),
    .pop_i   (pop)
  );

  vfu_ctrl #(
    .N_LANES (N_LANES)
  ) i_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (head_req),
    .req_valid_i  (head_valid),
    .rvalid_i     (vrf_rvalid_i),
    .rsp_ready_i  (rsp_ready_i),
    .pop_o        (pop),
    .issue_o      (issue),
    .tag_o        (issue_tag),
    .res_valid_i  (res_valid),
    .res_tag_i    (res_tag),
    .res_scalar_i (res_data[ELEN-1:0]),
    .rsp_o        (rsp_o),
    .rsp_valid_o  (rsp_valid_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // VRF side and lanes
  ////////////////////////////////////////////////////////////////////////////

  vfu_vrf_requester #(
    .N_LANES (N_LANES)
  ) i_vrf_requester (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (head_req),
    .req_valid_i (head_valid),
    .issue_i     (issue),
    .res_valid_i (res_valid),
    .res_tag_i   (res_tag),
    .res_data_i  (res_data),
    .raddr_o     (vrf_raddr_o),
    .re_o        (vrf_re_o),
    .waddr_o     (vrf_waddr_o),
    .wdata_o     (vrf_wdata_o),
    .we_o        (vrf_we_o),
    .wbe_o       (vrf_wbe_o)
  );

  vfu_ipu_array #(
    .N_LANES (N_LANES)
  ) i_ipu_array (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (head_req),
    .issue_i     (issue),
    .tag_i       (issue_tag),
    .vrf_rdata_i (vrf_rdata_i),
    .res_o       (res_data),
    .res_valid_o (res_valid),
    .tag_o       (res_tag)
  );

endmodule : spatz_vfu

`default_nettype wire

// File: src/vfu_ctrl.sv
/*
  Issue control for the head instruction. A word issues when every
  enabled operand is valid. The last word also waits for rsp_ready_i.
  The response is a one-cycle pulse when the last tag returns.
*/
`timescale 1ns/10ps
`default_nettype none

module vfu_ctrl #(
  parameter int unsigned N_LANES = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  vfu_pkg::vfu_req_t req_i,
  input  logic              req_valid_i,
  input  logic [1:0]        rvalid_i,
  input  logic              rsp_ready_i,
  output logic              pop_o,
  output logic              issue_o,
  output vfu_pkg::vfu_tag_t tag_o,
  input  logic              res_valid_i,
  input  vfu_pkg::vfu_tag_t res_tag_i,
  input  logic [31:0]       res_scalar_i,
  output vfu_pkg::vfu_rsp_t rsp_o,
  output logic              rsp_valid_o
);
  import vfu_pkg::*;

  vlen_t    elem_cnt_q;
  vlen_t    elem_per_word;
  vlen_t    elem_left;
  logic     last_word;
  logic     operands_ok;
  nr_elem_t nr_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////////////////////////////////////////

  // Elements per VRF word shrink as the element width grows
  assign elem_per_word = vlen_t'(N_LANES * (4 >> req_i.vsew));
  assign elem_left     = req_i.vl - elem_cnt_q;
  assign last_word     = req_i.is_scalar || (elem_left <= elem_per_word);

  // vs2 is always read by vector ops, vs1 only if used
  assign operands_ok = req_i.is_scalar ||
                       (rvalid_i[0] && (!req_i.use_vs1 || rvalid_i[1]));

  assign issue_o = req_valid_i && operands_ok && (!last_word || rsp_ready_i);
  assign pop_o   = issue_o && last_word;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      elem_cnt_q <= '0;
    end else if (pop_o) begin
      elem_cnt_q <= '0;
    end else if (issue_o) begin
      elem_cnt_q <= elem_cnt_q + elem_per_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tag and response
  ////////////////////////////////////////////////////////////////////////////

  assign nr_valid = req_i.is_scalar ? nr_elem_t'(1) :
                    last_word       ? nr_elem_t'(elem_left) :
                                      nr_elem_t'(elem_per_word);

  assign tag_o = '{
    id:            req_i.id,
    rd:            req_i.rd,
    wb:            req_i.is_scalar,
    last:          last_word,
    nr_valid_elem: nr_valid
  };

  // Retire on the returning last word
  assign rsp_valid_o = res_valid_i && res_tag_i.last;
  assign rsp_o = '{
    id:     res_tag_i.id,
    rd:     res_tag_i.rd,
    wb:     res_tag_i.wb,
    result: res_tag_i.wb ? res_scalar_i : 32'd0
  };

endmodule : vfu_ctrl

`default_nettype wire

// File: src/vfu_op_queue.sv
/*
  Two-entry request queue. ready_o depends only on the fill level,
  so there is no combinational path from pop_i to ready_o.
  A pop with an empty queue is ignored.
*/
`timescale 1ns/10ps
`default_nettype none

module vfu_op_queue (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  vfu_pkg::vfu_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output vfu_pkg::vfu_req_t req_o,
  output logic              valid_o,
  input  logic              pop_i
);
  import vfu_pkg::*;

  vfu_req_t [1:0] mem_q;
  logic           wr_ptr_q;
  logic           rd_ptr_q;
  logic [1:0]     cnt_q;
  logic           push;
  logic           pop;

  assign ready_o = (cnt_q != 2'd2);
  assign valid_o = (cnt_q != 2'd0);
  assign req_o   = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Count moves only when exactly one side fires
      if (push && !pop) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

endmodule : vfu_op_queue

`default_nettype wire

// File: src/vfu_vrf_requester.sv
/*
  VRF address generation and write-back. Word pointers reload from the
  head whenever the previous instruction has retired. Writes land one
  cycle after issue and mask bytes past the valid elements.
*/
`timescale 1ns/10ps
`default_nettype none

module vfu_vrf_requester #(
  parameter int unsigned N_LANES = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  vfu_pkg::vfu_req_t                   req_i,
  input  logic                                req_valid_i,
  input  logic                                issue_i,
  input  logic                                res_valid_i,
  input  vfu_pkg::vfu_tag_t                   res_tag_i,
  input  logic [N_LANES*vrf_pkg::ELEN-1:0]    res_data_i,
  output vrf_pkg::vreg_addr_t [1:0]           raddr_o,
  output logic [1:0]                          re_o,
  output vrf_pkg::vreg_addr_t                 waddr_o,
  output logic [N_LANES*vrf_pkg::ELEN-1:0]    wdata_o,
  output logic                                we_o,
  output logic [N_LANES*vrf_pkg::ELENB-1:0]   wbe_o
);
  import vfu_pkg::*;
  import vrf_pkg::*;

  localparam int unsigned BE_W = N_LANES * ELENB;

  // Word pointers for vs2, vs1 and vd
  vreg_addr_t [2:0]         addr_q;
  vreg_addr_t [2:0]         addr_cur;
  vreg_addr_t               waddr_q;
  ew_e                      wr_vsew_q;
  logic                     fresh_q;
  logic                     head_new;
  logic [NR_ELEM_WIDTH+1:0] nr_bytes;

  // A returning last word means the head moved on this cycle
  assign head_new = fresh_q || (res_valid_i && res_tag_i.last);

  always_comb begin
    if (head_new) begin
      addr_cur[0] = vreg_addr_t'(req_i.vs2 * WORDS_PER_VREG);
      addr_cur[1] = vreg_addr_t'(req_i.vs1 * WORDS_PER_VREG);
      addr_cur[2] = vreg_addr_t'(req_i.vd * WORDS_PER_VREG);
    end else begin
      addr_cur = addr_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fresh_q <= 1'b1;
    end else if (issue_i) begin
      fresh_q <= 1'b0;
    end else if (head_new) begin
      fresh_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      for (int p = 0; p < 3; p++) begin
        addr_q[p] <= addr_cur[p] + 1'b1;
      end
      waddr_q   <= addr_cur[2];
      wr_vsew_q <= req_i.vsew;
    end
  end

  assign raddr_o = addr_cur[1:0];
  assign re_o    = (req_valid_i && !req_i.is_scalar) ? {req_i.use_vs1, 1'b1} : 2'b00;

  // Scalar results go back in the response only
  assign nr_bytes = {2'b00, res_tag_i.nr_valid_elem} << wr_vsew_q;
  assign we_o     = res_valid_i && !res_tag_i.wb;
  assign wbe_o    = ~({BE_W{1'b1}} << nr_bytes);
  assign waddr_o  = waddr_q;
  assign wdata_o  = res_data_i;

endmodule : vfu_vrf_requester

`default_nettype wire
